// File: Makefile
SIM    = verilator
FLAGS  = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP    = tb_peri_hub
FLIST  = flist.f
BUILD  = obj_dir
LOG    = sim.log

.PHONY: simulate clean

# The run log decides pass or fail
simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: flist.f
logic/hub_pkg.sv
logic/addr_decode.sv
logic/read_return.sv
logic/gpio_block.sv
logic/edge_counter.sv
logic/peri_hub.sv
testbench/tb_peri_hub.sv

// File: logic/addr_decode.sv
// Hub address decoder
// Splits the address into full (64 byte) and simple (16 byte) slots,
// multiplexes read data and makes the per-slot write enables

module addr_decode (
    input  hub_pkg::bus_req_t          i_req,
    input  logic [hub_pkg::DATA_W-1:0] i_gpio_rdata,
    input  logic [7:0]                 i_edge_rdata,
    output hub_pkg::bus_rsp_t          o_peri_rsp,
    output logic                       o_gpio_sel,
    output logic                       o_gpio_we,
    output logic                       o_edge_we
);

    logic                       is_simple;
    logic [3:0]                 slot;
    logic                       wr_req;
    logic [hub_pkg::DATA_W-1:0] full_rdata   [hub_pkg::FULL_SLOTS];
    logic [7:0]                 simple_rdata [hub_pkg::SIMPLE_SLOTS];

    // 0x400 - 0x4ff is the simple slot window
    assign is_simple = (i_req.addr[10:9] == 2'b10);
    assign slot      = is_simple ? i_req.addr[7:4] : i_req.addr[9:6];
    assign wr_req    = (i_req.write_n != hub_pkg::REQ_NONE);

    // Empty slots read as zero
    always_comb begin
        for (int s = 0; s < hub_pkg::FULL_SLOTS; s++) begin
            full_rdata[s] = '0;
        end
        for (int s = 0; s < hub_pkg::SIMPLE_SLOTS; s++) begin
            simple_rdata[s] = '0;
        end
        full_rdata[hub_pkg::SLOT_GPIO]   = i_gpio_rdata;
        simple_rdata[hub_pkg::SLOT_EDGE] = i_edge_rdata;
    end

    always_comb begin
        if (is_simple) begin
            o_peri_rsp.data = {{(hub_pkg::DATA_W-8){1'b0}}, simple_rdata[slot]};
        end else begin
            o_peri_rsp.data = full_rdata[slot];
        end
        // Every slot answers in the cycle it is addressed
        o_peri_rsp.ready = 1'b1;
    end

    assign o_gpio_sel = !is_simple && (slot == 4'(hub_pkg::SLOT_GPIO));
    assign o_gpio_we  = o_gpio_sel && wr_req;
    assign o_edge_we  = is_simple && (slot == 4'(hub_pkg::SLOT_EDGE)) && wr_req;

    // The decode must never let a write land in two slots
    always_comb begin
        if (!$isunknown({o_gpio_we, o_edge_we})) begin
            a_one_write: assert ($onehot0({o_gpio_we, o_edge_we}))
                else $error("two slots write enabled at once");
        end
    end

endmodule

// File: logic/edge_counter.sv
// Edge counter byte peripheral
// Counts rising edges on one selectable input pin, the count wraps at 256
// and is also presented on the peripheral's pin outputs

module edge_counter (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_we,
    input  logic [3:0]     i_addr,
    input  logic [7:0]     i_wdata,
    input  hub_pkg::pins_t i_ui_in,
    output logic [7:0]     o_rdata,
    output hub_pkg::pins_t o_pins
);

    logic [2:0] pin_idx;
    logic       pin_q;
    logic       pin_prev;
    logic [7:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_idx  <= '0;
            pin_q    <= 1'b0;
            pin_prev <= 1'b0;
            count    <= '0;
        end else begin
            pin_q    <= i_ui_in[pin_idx];
            pin_prev <= pin_q;
            if (i_we && (i_addr == hub_pkg::EDGE_SEL_OFS)) begin
                pin_idx <= i_wdata[2:0];
            end
            // Clear wins over a coincident edge
            if (i_we && (i_addr == hub_pkg::EDGE_CNT_OFS)) begin
                count <= '0;
            end else if (pin_q && !pin_prev) begin
                count <= count + 8'd1;
            end
        end
    end

    always_comb begin
        case (i_addr)
            hub_pkg::EDGE_SEL_OFS: o_rdata = {5'b0, pin_idx};
            hub_pkg::EDGE_CNT_OFS: o_rdata = count;
            default:               o_rdata = '0;
        endcase
    end

    assign o_pins = count;

endmodule

// File: logic/gpio_block.sv
// GPIO block
// Output register, input port read and a 6-bit function select per pin,
// which routes any slot's pin output to that pin

module gpio_block (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_sel,
    input  logic                       i_we,
    input  logic [5:0]                 i_addr,
    input  logic [7:0]                 i_wdata,
    input  hub_pkg::pins_t             i_ui_in,
    input  hub_pkg::slot_pins_t        i_full_pins,
    input  hub_pkg::slot_pins_t        i_simple_pins,
    output logic [hub_pkg::DATA_W-1:0] o_rdata,
    output hub_pkg::pins_t             o_uo_out
);

    hub_pkg::pins_t      gpio_out;
    hub_pkg::pin_sel_t   func_sel [hub_pkg::PINS];
    hub_pkg::slot_pins_t full_pins;
    logic                sel_hit;
    logic [2:0]          sel_idx;

    // Select words sit at 0x20 + 4*pin, bits 4:2 carry the pin index
    assign sel_hit = ((i_addr & ~6'h1c) == hub_pkg::GPIO_SEL_BASE);
    assign sel_idx = i_addr[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (i_we && (i_addr == hub_pkg::GPIO_OUT_OFS)) begin
            gpio_out <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int n = 0; n < hub_pkg::PINS; n++) begin
                func_sel[n] <= '{spare: 1'b0, is_simple: 1'b0, slot: 4'(hub_pkg::SLOT_GPIO)};
            end
        end else if (i_we && sel_hit) begin
            func_sel[sel_idx] <= hub_pkg::pin_sel_t'(i_wdata[5:0]);
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_sel) begin
            if (i_addr == hub_pkg::GPIO_OUT_OFS) begin
                o_rdata[hub_pkg::PINS-1:0] = gpio_out;
            end else if (i_addr == hub_pkg::GPIO_IN_OFS) begin
                o_rdata[hub_pkg::PINS-1:0] = i_ui_in;
            end else if (sel_hit) begin
                o_rdata[5:0] = func_sel[sel_idx];
            end
        end
    end

    // GPIO is itself a full slot source
    always_comb begin
        full_pins = i_full_pins;
        full_pins[hub_pkg::SLOT_GPIO] = gpio_out;
    end

    // Pin n always takes bit n of whichever slot it points at
    for (genvar n = 0; n < hub_pkg::PINS; n++) begin : g_route
        assign o_uo_out[n] = func_sel[n].is_simple ?
                             i_simple_pins[func_sel[n].slot][n] :
                             full_pins[func_sel[n].slot][n];
    end

endmodule

// File: logic/hub_pkg.sv
// Peripheral hub shared definitions
// Bus widths, address map, register offsets and the bus and pin types
// used by every block of the hub

package hub_pkg;

    // Bus and pin widths
    localparam int unsigned ADDR_W = 11;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned PINS   = 8;

    // Address map
    localparam int unsigned FULL_SLOTS   = 16;
    localparam int unsigned SIMPLE_SLOTS = 16;
    localparam int unsigned SLOT_GPIO    = 1;
    localparam int unsigned SLOT_EDGE    = 0;

    // 00 = 8-bit, 01 = 16-bit, 10 = 32-bit, 11 = idle
    localparam logic [1:0] REQ_NONE = 2'b11;

    // GPIO register offsets within its 64 byte slot
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] GPIO_SEL_BASE = 6'h20;

    // Edge counter register offsets within its 16 byte slot
    localparam logic [3:0] EDGE_SEL_OFS = 4'h0;
    localparam logic [3:0] EDGE_CNT_OFS = 4'h1;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [1:0]        write_n;
        logic [1:0]        read_n;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              ready;
    } bus_rsp_t;

    // Output function select for one pin
    typedef struct packed {
        logic       spare;
        logic       is_simple;
        logic [3:0] slot;
    } pin_sel_t;

    typedef logic [PINS-1:0] pins_t;

    // One pin vector per slot, full and simple slots alike
    typedef pins_t [FULL_SLOTS-1:0] slot_pins_t;

endpackage

// File: logic/peri_hub.sv
// Peripheral hub top level
// Connects the address decoder, the registered read return, the GPIO
// block and the edge counter to the core-facing bus

module peri_hub (
    input  logic              clk,
    input  logic              rst_n,
    input  hub_pkg::bus_req_t i_req,
    input  hub_pkg::pins_t    i_ui_in,
    input  logic              i_read_complete,
    output hub_pkg::bus_rsp_t o_rsp,
    output hub_pkg::pins_t    o_uo_out
);

    hub_pkg::bus_rsp_t          peri_rsp;
    logic [hub_pkg::DATA_W-1:0] gpio_rdata;
    logic [7:0]                 edge_rdata;
    logic                       gpio_sel;
    logic                       gpio_we;
    logic                       edge_we;
    hub_pkg::pins_t             edge_pins;
    hub_pkg::slot_pins_t        full_pins;
    hub_pkg::slot_pins_t        simple_pins;
    logic [hub_pkg::DATA_W-1:0] rdata;
    logic                       rready;

    // No other full peripheral is fitted, GPIO drives its own entry
    assign full_pins = '0;

    always_comb begin
        simple_pins = '0;
        simple_pins[hub_pkg::SLOT_EDGE] = edge_pins;
    end

    addr_decode u_addr_decode (
        .i_req        (i_req),
        .i_gpio_rdata (gpio_rdata),
        .i_edge_rdata (edge_rdata),
        .o_peri_rsp   (peri_rsp),
        .o_gpio_sel   (gpio_sel),
        .o_gpio_we    (gpio_we),
        .o_edge_we    (edge_we)
    );

    read_return u_read_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_req.read_n),
        .i_peri_rsp      (peri_rsp),
        .i_read_complete (i_read_complete),
        .o_rdata         (rdata),
        .o_rready        (rready)
    );

    gpio_block u_gpio_block (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_sel         (gpio_sel),
        .i_we          (gpio_we),
        .i_addr        (i_req.addr[5:0]),
        .i_wdata       (i_req.wdata[7:0]),
        .i_ui_in       (i_ui_in),
        .i_full_pins   (full_pins),
        .i_simple_pins (simple_pins),
        .o_rdata       (gpio_rdata),
        .o_uo_out      (o_uo_out)
    );

    edge_counter u_edge_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_we    (edge_we),
        .i_addr  (i_req.addr[3:0]),
        .i_wdata (i_req.wdata[7:0]),
        .i_ui_in (i_ui_in),
        .o_rdata (edge_rdata),
        .o_pins  (edge_pins)
    );

    // Writes complete in their own cycle
    assign o_rsp.data  = rdata;
    assign o_rsp.ready = rready || (i_req.write_n != hub_pkg::REQ_NONE);

endmodule

// File: logic/read_return.sv
// Registered read return
// Captures the selected slot's data on the first read cycle and holds it
// until the core signals that the read is complete

module read_return (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [1:0]                 i_read_n,
    input  hub_pkg::bus_rsp_t          i_peri_rsp,
    input  logic                       i_read_complete,
    output logic [hub_pkg::DATA_W-1:0] o_rdata,
    output logic                       o_rready
);

    typedef enum logic {
        IDLE,
        HOLD
    } state_t;

    state_t state;
    logic   read_req;
    logic   capture;

    assign read_req = (i_read_n != hub_pkg::REQ_NONE);
    assign capture  = (state == IDLE) && read_req && i_peri_rsp.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            o_rready <= 1'b0;
        end else begin
            // Ready lags the data by one cycle to match the capture
            o_rready <= read_req && i_peri_rsp.ready;
            case (state)
                IDLE: if (capture) state <= HOLD;
                HOLD: if (i_read_complete) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_rdata <= i_peri_rsp.data;
        end
    end

    a_no_ready_after_reset: assert property (@(posedge clk) !rst_n |=> !o_rready)
        else $error("read ready high straight after reset");

    // Core may sample the data at any point until it completes the read
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        state == HOLD |=> $stable(o_rdata))
        else $error("held read data changed");

endmodule

// File: testbench/tb_peri_hub.sv
// Testbench for the peripheral hub
// Applies a table of bus writes, reads, edge bursts and pin checks to the
// hub and reports the overall result

module tb_peri_hub;

    timeunit 1ns;
    timeprecision 1ns;

    typedef enum logic [2:0] {K_WRITE, K_READ, K_PINS, K_INPUT, K_EDGES} kind_t;

    // For K_READ wdata is the read_complete delay, for K_EDGES addr is the pin
    // and wdata the edge count, for K_INPUT wdata is the number of trials
    typedef struct packed {
        kind_t                      kind;
        logic [hub_pkg::ADDR_W-1:0] addr;
        logic [hub_pkg::DATA_W-1:0] wdata;
        logic [hub_pkg::DATA_W-1:0] expected;
    } step_t;

    // GPIO is full slot 1 at 0x040, edge counter is simple slot 0 at 0x400
    localparam logic [hub_pkg::ADDR_W-1:0] A_SEL0     = 11'h060;
    localparam logic [hub_pkg::ADDR_W-1:0] A_EDGE_SEL = 11'h400;
    localparam logic [hub_pkg::ADDR_W-1:0] A_EDGE_CNT = 11'h401;
    localparam int READ_TIMEOUT = 20;

    logic              clk = 1'b0;
    logic              rst_n;
    hub_pkg::bus_req_t req;
    hub_pkg::pins_t    ui_in;
    logic              read_complete;
    hub_pkg::bus_rsp_t rsp;
    hub_pkg::pins_t    uo_out;
    integer            seed;
    step_t             steps [$];

    peri_hub DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (req),
        .i_ui_in         (ui_in),
        .i_read_complete (read_complete),
        .o_rsp           (rsp),
        .o_uo_out        (uo_out)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [hub_pkg::DATA_W-1:0] expected,
                              input hub_pkg::bus_rsp_t actual);
        if (actual.data !== expected) begin
            report_failure($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                                     name, expected, actual.data));
        end
    endtask

    task automatic check_pins(input string name, input hub_pkg::pins_t expected,
                              input hub_pkg::pins_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_ready(input string name, input logic expected,
                               input hub_pkg::bus_rsp_t actual);
        if (actual.ready !== expected) begin
            report_failure($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                                     name, expected, actual.ready));
        end
    endtask

    task automatic bus_write(input logic [hub_pkg::ADDR_W-1:0] addr,
                             input logic [hub_pkg::DATA_W-1:0] wdata);
        @(negedge clk);
        req.addr    = addr;
        req.wdata   = wdata;
        req.write_n = 2'b10;
        #10;
        check_ready("o_rsp.ready", 1'b1, rsp);
        @(negedge clk);
        req.write_n = hub_pkg::REQ_NONE;
    endtask

    task automatic bus_read(input logic [hub_pkg::ADDR_W-1:0] addr, input int hold_cycles,
                            output hub_pkg::bus_rsp_t got);
        int waited;
        waited = 0;
        @(negedge clk);
        req.addr   = addr;
        req.read_n = 2'b10;
        @(negedge clk);
        while (!rsp.ready) begin
            if (waited == READ_TIMEOUT) begin
                report_failure("Read got no ready from the hub before the timeout");
            end
            waited++;
            @(negedge clk);
        end
        got = rsp;
        // Steer the address elsewhere so only the held value can still match
        req.addr = addr ^ 11'h040;
        // A slow core must still see the captured value
        for (int c = 0; c < hold_cycles; c++) begin
            @(negedge clk);
            check_word("o_rsp.data held", got.data, rsp);
        end
        req.read_n    = hub_pkg::REQ_NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
    endtask

    task automatic run_edges(input logic [2:0] pin, input int count);
        ui_in = '0;
        bus_write(A_EDGE_SEL, {29'b0, pin});
        repeat (3) @(negedge clk);
        bus_write(A_EDGE_CNT, 32'h0);
        for (int e = 0; e < count; e++) begin
            ui_in[pin] = 1'b1;
            @(negedge clk);
            ui_in[pin] = 1'b0;
            @(negedge clk);
        end
        // The last edge reaches the count two clock edges after it is applied
        repeat (2) @(negedge clk);
    endtask

    function automatic void add_step(input kind_t kind, input logic [10:0] addr,
                                     input logic [31:0] wdata, input logic [31:0] expected);
        step_t st;
        st.kind     = kind;
        st.addr     = addr;
        st.wdata    = wdata;
        st.expected = expected;
        steps.push_back(st);
    endfunction

    function automatic void build_table();
        add_step(K_READ,  11'h040, 32'd0,   32'h00);
        add_step(K_WRITE, 11'h040, 32'ha5,  32'h00);
        add_step(K_READ,  11'h040, 32'd0,   32'ha5);
        add_step(K_PINS,  11'h000, 32'd0,   32'ha5);
        add_step(K_WRITE, 11'h040, 32'h3c,  32'h00);
        add_step(K_PINS,  11'h000, 32'd0,   32'h3c);
        add_step(K_READ,  11'h040, 32'd0,   32'h3c);
        add_step(K_WRITE, 11'h040, 32'h00,  32'h00);
        add_step(K_PINS,  11'h000, 32'd0,   32'h00);
        add_step(K_INPUT, 11'h044, 32'd6,   32'h00);
        // Edge bursts, counts above 256 wrap
        add_step(K_EDGES, 11'h002, 32'd5,   32'h05);
        add_step(K_EDGES, 11'h006, 32'd300, 32'h2c);
        add_step(K_EDGES, 11'h001, 32'd267, 32'h0b);
        add_step(K_WRITE, 11'h401, 32'h5a,  32'h00);
        add_step(K_READ,  11'h401, 32'd0,   32'h00);
        add_step(K_EDGES, 11'h004, 32'd12,  32'h0c);
        // Pin 3 follows count bit 3 once routed to the edge counter
        add_step(K_WRITE, 11'h06c, 32'h10,  32'h00);
        add_step(K_READ,  11'h06c, 32'd0,   32'h10);
        add_step(K_PINS,  11'h000, 32'd0,   32'h08);
        add_step(K_WRITE, 11'h040, 32'hf0,  32'h00);
        add_step(K_PINS,  11'h000, 32'd0,   32'hf8);
        add_step(K_EDGES, 11'h004, 32'd5,   32'h05);
        add_step(K_PINS,  11'h000, 32'd0,   32'hf0);
        add_step(K_WRITE, 11'h074, 32'h03,  32'h00);
        add_step(K_READ,  11'h074, 32'd0,   32'h03);
        add_step(K_PINS,  11'h000, 32'd0,   32'hd0);
        add_step(K_WRITE, 11'h07c, 32'h15,  32'h00);
        add_step(K_PINS,  11'h000, 32'd0,   32'h50);
        // Empty full and simple slots
        add_step(K_READ,  11'h000, 32'd0,   32'h00);
        add_step(K_READ,  11'h080, 32'd0,   32'h00);
        add_step(K_READ,  11'h450, 32'd0,   32'h00);
        add_step(K_READ,  11'h4f0, 32'd0,   32'h00);
        add_step(K_READ,  11'h040, 32'd4,   32'hf0);
        add_step(K_READ,  11'h401, 32'd3,   32'h05);
    endfunction

    initial begin
        step_t             st;
        hub_pkg::bus_rsp_t got;
        hub_pkg::pins_t    pins_val;
        seed          = 32'hb822_a4fe;
        req.addr      = '0;
        req.wdata     = '0;
        req.write_n   = hub_pkg::REQ_NONE;
        req.read_n    = hub_pkg::REQ_NONE;
        ui_in         = '0;
        read_complete = 1'b0;
        rst_n         = 1'b0;
        build_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_pins("o_uo_out", 8'h00, uo_out);
        for (int n = 0; n < hub_pkg::PINS; n++) begin
            bus_read(A_SEL0 + 11'(4 * n), 0, got);
            check_word("pin select", 32'(hub_pkg::SLOT_GPIO), got);
        end
        foreach (steps[i]) begin
            st = steps[i];
            case (st.kind)
                K_WRITE: bus_write(st.addr, st.wdata);
                K_READ: begin
                    bus_read(st.addr, int'(st.wdata), got);
                    check_word("o_rsp.data", st.expected, got);
                end
                K_PINS: check_pins("o_uo_out", st.expected[7:0], uo_out);
                K_INPUT: begin
                    for (int t = 0; t < int'(st.wdata); t++) begin
                        ui_in    = hub_pkg::pins_t'($random(seed));
                        pins_val = ui_in;
                        bus_read(st.addr, 0, got);
                        check_word("gpio input", 32'(pins_val), got);
                    end
                end
                K_EDGES: begin
                    run_edges(st.addr[2:0], int'(st.wdata));
                    bus_read(A_EDGE_CNT, 0, got);
                    check_word("edge count", st.expected, got);
                end
                default: report_failure("Table holds an unknown step kind");
            endcase
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule
